// File: project.f
+incdir+verilog
verilog/sms_loader_pkg.sv
verilog/rom_write_seq.sv
verilog/cart_info.sv
verilog/cheat_code_loader.sv
verilog/sms_loader_top.sv
tb/sms_loader_chk.sv
tb/sms_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SMS loader testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module sms_loader_tb \
	-f project.f \
	-o sms_loader_sim

# Keep running past assertion errors so the testbench prints its result
status=0
./obj_dir/sms_loader_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log || [ "$status" -ne 0 ]; then
	exit 1
fi
exit 0

// File: tb/sms_loader_tb.sv
// SMS loader testbench
`timescale 1ns/100ps
`default_nettype none

`include "sms_loader_settings.svh"

module sms_loader_tb;

	localparam int clk_period  = 4;
	localparam int total_bytes = 2048 + 2560 + `SMS_CODE_BYTES + 1 + `SMS_DSW_COUNT + 16 + 16 + 5;
	localparam int timeout_ns  = (total_bytes * 50 + 2000) * clk_period;

	logic                          clk_sys;
	logic                          RESET;
	logic                          ioctl_download;
	sms_loader_pkg::byte_t         ioctl_index;
	logic                          ioctl_wr;
	sms_loader_pkg::ioctl_addr_t   ioctl_addr;
	sms_loader_pkg::byte_t         ioctl_dout;
	logic                          rom_wr_ack;
	sms_loader_pkg::rom_addr_t     rom_rd_addr;
	logic                          ioctl_wait;
	logic                          rom_wr;
	sms_loader_pkg::waddr_t        rom_waddr;
	sms_loader_pkg::byte_t         rom_wdata;
	sms_loader_pkg::rom_addr_t     rom_addr;
	logic                          gg;
	logic                          systeme;
	logic                          palettemode;
	sms_loader_pkg::byte_t         sysmode;
	sms_loader_pkg::byte_t         dsw0;
	sms_loader_pkg::byte_t         dsw1;
	sms_loader_pkg::byte_t         dsw2;
	logic                          code_valid;
	sms_loader_pkg::cheat_code_t   cheat_code;

	sms_loader_pkg::byte_t sent [0:4095]; // Bytes of the current file
	sms_loader_pkg::byte_t mem  [0:4095]; // External memory model
	int                    errors;
	int                    checks;
	int                    valid_cycles;
	int                    ack_count;
	logic                  in_reset;
	logic                  hold_ack;      // Stalls the memory echo

	sms_loader_top dut (.*);

	bind sms_loader_top sms_loader_chk u_chk (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.ioctl_wait (ioctl_wait),
		.rom_wr     (rom_wr),
		.rom_wr_ack (rom_wr_ack),
		.rom_waddr  (rom_waddr),
		.rom_wdata  (rom_wdata),
		.code_valid (code_valid)
	);

	initial clk_sys = 1'b0;
	always #(clk_period / 2) clk_sys = ~clk_sys;

	// ====================
	// Memory model
	// ====================
	initial begin : memory_model
		rom_wr_ack = 1'b0;
		ack_count  = 0;
		forever begin
			@(posedge clk_sys);
			in_reset = RESET; // As seen by the DUT at this edge
			#1;
			if (in_reset) begin
				rom_wr_ack = 1'b0;
				ack_count  = 0;
			end else if (!hold_ack && (rom_wr !== rom_wr_ack)) begin
				if (ack_count == 0)
					ack_count = $urandom_range(4, 1);
				ack_count = ack_count - 1;
				if (ack_count == 0) begin
					mem[rom_waddr[11:0]] = rom_wdata;
					rom_wr_ack = rom_wr; // Echo completes the write
				end
			end
		end
	end

	// Length of every code_valid pulse
	always @(negedge clk_sys) begin
		if (code_valid === 1'b1)
			valid_cycles = valid_cycles + 1;
	end

	initial begin : watchdog
		#(timeout_ns);
		$display("Timeout: the run did not finish within %0d ns", timeout_ns);
		$display("SIMULATION FAILED");
		$finish;
	end

	task automatic check_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		checks = checks + 1;
		assert (actual === expected) else begin
			errors = errors + 1;
			$display("ERR %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic check_memory(input string name, input int count);
		int i;
		for (i = 0; i < count; i++)
			check_value($sformatf("%s[%0d]", name, i), sent[i], mem[i]);
	endtask

	// Called and left at 1 ns after a rising edge
	task automatic send_byte(input int addr, input sms_loader_pkg::byte_t data);
		while (ioctl_wait) begin
			@(posedge clk_sys);
			#1;
		end
		ioctl_wr   = 1'b1;
		ioctl_addr = sms_loader_pkg::ioctl_addr_t'(addr);
		ioctl_dout = data;
		@(posedge clk_sys);
		#1;
		ioctl_wr = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic send_file(input sms_loader_pkg::byte_t index, input int count);
		int i;
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(posedge clk_sys);
		#1;
		for (i = 0; i < count; i++)
			send_byte(i, sent[i]);
		while (ioctl_wait) begin // Last write still in flight
			@(posedge clk_sys);
			#1;
		end
		ioctl_download = 1'b0;
		repeat (2) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic check_map(input string name, input bit header);
		sms_loader_pkg::rom_addr_t rd;
		repeat (20) begin
			rd          = sms_loader_pkg::rom_addr_t'($urandom);
			rom_rd_addr = rd;
			#1;
			if (header)
				check_value(name, (rd + 22'd512) & 22'd2047, rom_addr);
			else
				check_value(name, rd & 22'd2047, rom_addr);
			@(posedge clk_sys);
			#1;
		end
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin : stimulus
		logic [127:0] code_exp;
		int           i;
		void'($urandom(32'h5a90));
		errors         = 0;
		checks         = 0;
		valid_cycles   = 0;
		hold_ack       = 1'b0;
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		rom_rd_addr    = '0;
		repeat (16) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		@(posedge clk_sys);
		#1;

		// Plain 2 KB cartridge
		for (i = 0; i < 2048; i++)
			sent[i] = sms_loader_pkg::byte_t'($urandom);
		send_file({3'b000, `SMS_INDEX_SMS}, 2048);
		check_memory("cart_2048", 2048);
		check_value("cart_2048_waddr", 2048, rom_waddr);
		check_value("palettemode_sms", 0, palettemode);
		check_map("map_plain", 1'b0);

		// Same size behind a copier header
		for (i = 0; i < 2560; i++)
			sent[i] = sms_loader_pkg::byte_t'($urandom);
		send_file({3'b000, `SMS_INDEX_SMS}, 2560);
		check_memory("cart_2560", 2560);
		check_map("map_header", 1'b1);

		// Cheat file, words lowest byte first, flags on top
		code_exp = '0;
		for (i = 0; i < `SMS_CODE_BYTES; i++) begin
			sent[i] = sms_loader_pkg::byte_t'(8'h30 + i * 7);
			code_exp[(3 - i / 4) * 32 + (i % 4) * 8 +: 8] = sent[i];
		end
		valid_cycles = 0;
		send_file(`SMS_INDEX_CODE, `SMS_CODE_BYTES);
		check_value("code_pulse_cycles", 1, valid_cycles);
		check_value("code_fields", code_exp, cheat_code);

		// Arcade registers
		sent[0] = 8'hA5;
		send_file(`SMS_INDEX_SYSMODE, 1);
		sent[0] = 8'h3C;
		sent[1] = 8'h81;
		sent[2] = 8'h7E;
		send_file(`SMS_INDEX_DSW, `SMS_DSW_COUNT);
		check_value("sysmode", 8'hA5, sysmode);
		check_value("dsw0", 8'h3C, dsw0);
		check_value("dsw1", 8'h81, dsw1);
		check_value("dsw2", 8'h7E, dsw2);
		check_value("systeme_set", 1, systeme);

		// GG cartridge leaves arcade mode
		for (i = 0; i < 16; i++)
			sent[i] = sms_loader_pkg::byte_t'($urandom);
		send_file({3'b000, `SMS_INDEX_GG}, 16);
		check_value("systeme_clear", 0, systeme);
		check_value("gg_set", 1, gg);

		// SG file turns on the legacy palette
		send_file({1'b0, `SMS_EXT_SG, `SMS_INDEX_SMS}, 16);
		check_value("palettemode_sg", 1, palettemode);

		// Reset with a write in flight
		ioctl_index    = {3'b000, `SMS_INDEX_SMS};
		ioctl_download = 1'b1;
		@(posedge clk_sys);
		#1;
		for (i = 0; i < 4; i++)
			send_byte(i, sent[i]);
		while (ioctl_wait) begin
			@(posedge clk_sys);
			#1;
		end
		hold_ack   = 1'b1; // Next write stays pending
		ioctl_wr   = 1'b1;
		ioctl_addr = 4;
		ioctl_dout = sent[4];
		@(posedge clk_sys);
		#1;
		ioctl_wr = 1'b0;
		check_value("wait_before_reset", 1, ioctl_wait);
		RESET = 1'b1;
		@(posedge clk_sys);
		#1;
		RESET = 1'b0;
		check_value("wait_after_reset", 0, ioctl_wait);
		check_value("rom_wr_after_reset", 0, rom_wr);
		hold_ack       = 1'b0;
		ioctl_download = 1'b0;
		repeat (4) @(posedge clk_sys);

		$display("Result: %0d checks, %0d value errors, %0d protocol errors",
			checks, errors, dut.u_chk.fail_count);
		if (errors == 0 && dut.u_chk.fail_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/sms_loader_chk.sv
// Loader protocol checks
`timescale 1ns/100ps
`default_nettype none

module sms_loader_chk (
	input wire                      clk_sys,
	input wire                      RESET,
	input wire                      ioctl_wait,
	input wire                      rom_wr,
	input wire                      rom_wr_ack,
	input sms_loader_pkg::waddr_t   rom_waddr,
	input sms_loader_pkg::byte_t    rom_wdata,
	input wire                      code_valid
);

	int   fail_count = 0;
	logic pending;

	assign pending = rom_wr != rom_wr_ack; // Toggle not yet echoed

	// ====================
	// Write handshake
	// ====================
	// Toggle idle over a whole cycle
	wait_released: assert property (@(posedge clk_sys) disable iff (RESET)
		(!pending && $past(!pending) && $stable(rom_wr)) |-> !ioctl_wait)
	else begin
		fail_count = fail_count + 1;
		$error("ioctl_wait held high with no write pending");
	end

	// Address and data frozen until the echo
	write_stable: assert property (@(posedge clk_sys) disable iff (RESET)
		(pending && $past(pending)) |-> ($stable(rom_waddr) && $stable(rom_wdata)))
	else begin
		fail_count = fail_count + 1;
		$error("rom_waddr or rom_wdata changed during a pending write");
	end

	// ====================
	// Cheat strobe and reset
	// ====================
	valid_single: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
	else begin
		fail_count = fail_count + 1;
		$error("code_valid lasted more than one cycle");
	end

	reset_quiet: assert property (@(posedge clk_sys)
		$fell(RESET) |-> (!ioctl_wait && !code_valid))
	else begin
		fail_count = fail_count + 1;
		$error("ioctl_wait or code_valid high right after reset");
	end

endmodule

`default_nettype wire

// File: verilog/sms_loader_top.sv
// SMS cartridge loader
`timescale 1ns/100ps
`default_nettype none

`include "sms_loader_settings.svh"

module sms_loader_top (
	input  wire                           clk_sys,
	input  wire                           RESET,
	input  wire                           ioctl_download,
	input  sms_loader_pkg::byte_t         ioctl_index,
	input  wire                           ioctl_wr,
	input  sms_loader_pkg::ioctl_addr_t   ioctl_addr,
	input  sms_loader_pkg::byte_t         ioctl_dout,
	input  wire                           rom_wr_ack,
	input  sms_loader_pkg::rom_addr_t     rom_rd_addr,
	output logic                          ioctl_wait,
	output logic                          rom_wr,
	output sms_loader_pkg::waddr_t        rom_waddr,
	output sms_loader_pkg::byte_t         rom_wdata,
	output sms_loader_pkg::rom_addr_t     rom_addr,
	output logic                          gg,
	output logic                          systeme,
	output logic                          palettemode,
	output sms_loader_pkg::byte_t         sysmode,
	output sms_loader_pkg::byte_t         dsw0,
	output sms_loader_pkg::byte_t         dsw1,
	output sms_loader_pkg::byte_t         dsw2,
	output logic                          code_valid,
	output sms_loader_pkg::cheat_code_t   cheat_code
);

	logic code_index;
	logic is_sysmode;
	logic is_dsw;
	logic code_download;
	logic cart_download;

	// ====================
	// Download classes
	// ====================
	assign code_index    = ioctl_index == `SMS_INDEX_CODE;
	assign is_sysmode    = ioctl_index == `SMS_INDEX_SYSMODE;
	assign is_dsw        = ioctl_index == `SMS_INDEX_DSW;
	assign code_download = ioctl_download & code_index;
	assign cart_download = ioctl_download & ~code_index & ~is_sysmode & ~is_dsw; // ROM data

	rom_write_seq u_rom_write_seq (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_dout    (ioctl_dout),
		.rom_wr_ack    (rom_wr_ack),
		.ioctl_wait    (ioctl_wait),
		.rom_wr        (rom_wr),
		.rom_waddr     (rom_waddr),
		.rom_wdata     (rom_wdata)
	);

	cart_info u_cart_info (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.is_sysmode    (is_sysmode),
		.is_dsw        (is_dsw),
		.ioctl_wr      (ioctl_wr),
		.ioctl_index   (ioctl_index),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.rom_rd_addr   (rom_rd_addr),
		.rom_addr      (rom_addr),
		.gg            (gg),
		.systeme       (systeme),
		.palettemode   (palettemode),
		.sysmode       (sysmode),
		.dsw0          (dsw0),
		.dsw1          (dsw1),
		.dsw2          (dsw2)
	);

	cheat_code_loader u_cheat_code_loader (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.code_download (code_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.code_valid    (code_valid),
		.cheat_code    (cheat_code)
	);

endmodule

`default_nettype wire

// File: verilog/cheat_code_loader.sv
// Cheat code assembler
`timescale 1ns/100ps
`default_nettype none

`include "sms_loader_settings.svh"

module cheat_code_loader (
	input  wire                           clk_sys,
	input  wire                           RESET,
	input  wire                           code_download,
	input  wire                           ioctl_wr,
	input  sms_loader_pkg::ioctl_addr_t   ioctl_addr,
	input  sms_loader_pkg::byte_t         ioctl_dout,
	output logic                          code_valid,
	output sms_loader_pkg::cheat_code_t   cheat_code
);

	localparam int sel_w = $clog2(`SMS_CODE_BYTES);

	logic [sel_w-1:0] byte_sel;
	logic [1:0]       lane;     // Byte within a word
	logic             code_byte;
	logic             last_byte;

	assign byte_sel  = ioctl_addr[sel_w-1:0];
	assign lane      = byte_sel[1:0];
	assign code_byte = code_download & ioctl_wr;
	assign last_byte = byte_sel == sel_w'(`SMS_CODE_BYTES - 1);

	// ====================
	// Byte assembly
	// ====================
	always_ff @(posedge clk_sys) begin
		if (code_byte) begin
			// Each word arrives lowest byte first
			case (byte_sel[3:2])
				2'd0: cheat_code.flags[lane*8 +: 8]   <= ioctl_dout;
				2'd1: cheat_code.address[lane*8 +: 8] <= ioctl_dout;
				2'd2: cheat_code.compare[lane*8 +: 8] <= ioctl_dout;
				default: cheat_code.replace[lane*8 +: 8] <= ioctl_dout;
			endcase
		end
	end

	// One pulse when the last byte lands
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= code_byte & last_byte;
	end

endmodule

`default_nettype wire

// File: verilog/cart_info.sv
// Cartridge geometry and flags
`timescale 1ns/100ps
`default_nettype none

`include "sms_loader_settings.svh"

module cart_info (
	input  wire                          clk_sys,
	input  wire                          RESET,
	input  wire                          cart_download,
	input  wire                          is_sysmode,
	input  wire                          is_dsw,
	input  wire                          ioctl_wr,
	input  sms_loader_pkg::byte_t        ioctl_index,
	input  sms_loader_pkg::ioctl_addr_t  ioctl_addr,
	input  sms_loader_pkg::byte_t        ioctl_dout,
	input  sms_loader_pkg::rom_addr_t    rom_rd_addr,
	output sms_loader_pkg::rom_addr_t    rom_addr,
	output logic                         gg,
	output logic                         systeme,
	output logic                         palettemode,
	output sms_loader_pkg::byte_t        sysmode,
	output sms_loader_pkg::byte_t        dsw0,
	output sms_loader_pkg::byte_t        dsw1,
	output sms_loader_pkg::byte_t        dsw2
);

	localparam int size_w    = $clog2(`SMS_HEADER_BYTES) + 1;
	localparam int dsw_sel_w = $clog2(`SMS_DSW_COUNT);

	sms_loader_pkg::rom_addr_t cart_mask;
	sms_loader_pkg::rom_addr_t cart_mask512;
	sms_loader_pkg::rom_addr_t rom_low;
	sms_loader_pkg::byte_t     dsw [`SMS_DSW_COUNT];
	logic [size_w-1:0]         byte_cnt; // Low bits of bytes loaded
	logic                      cart_sz512;
	logic                      old_download;
	logic                      file_sms;
	logic                      file_gg;

	assign rom_low  = ioctl_addr[`SMS_ROM_ADDR_W-1:0];
	assign file_sms = ioctl_index[4:0] == `SMS_INDEX_SMS;
	assign file_gg  = ioctl_index[4:0] == `SMS_INDEX_GG;

	// ====================
	// Masks and flags
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			cart_mask    <= '1;
			cart_mask512 <= '1;
			byte_cnt     <= '0;
			cart_sz512   <= 1'b0;
			gg           <= 1'b0;
			systeme      <= 1'b0;
			palettemode  <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (ioctl_wr && cart_download) begin
				cart_mask    <= (ioctl_addr == 0) ? '0 : (cart_mask | rom_low);
				cart_mask512 <= (ioctl_addr == `SMS_HEADER_BYTES) ? '0 :
					(cart_mask512 | (rom_low - sms_loader_pkg::rom_addr_t'(`SMS_HEADER_BYTES)));
				byte_cnt     <= ioctl_addr[size_w-1:0] + 1'b1;
				if (file_sms || file_gg)
					systeme <= 1'b0;
				if (file_sms && (ioctl_index[6:5] == `SMS_EXT_SG))
					palettemode <= 1'b1; // .SG file
				gg <= file_gg;
			end
			// Odd half-KB size means a copier header
			if (old_download && !cart_download)
				cart_sz512 <= byte_cnt[size_w-1];
			if (ioctl_wr && is_sysmode)
				systeme <= 1'b1;
		end
	end

	// Arcade registers
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr && is_sysmode && (ioctl_addr == 0))
			sysmode <= ioctl_dout;
		if (ioctl_wr && is_dsw && (ioctl_addr < `SMS_DSW_COUNT))
			dsw[ioctl_addr[dsw_sel_w-1:0]] <= ioctl_dout;
	end

	assign dsw0 = dsw[0];
	assign dsw1 = dsw[1];
	assign dsw2 = dsw[2];

	// Skip the header when one is present
	assign rom_addr = cart_sz512 ?
		((rom_rd_addr + sms_loader_pkg::rom_addr_t'(`SMS_HEADER_BYTES)) & cart_mask512) :
		(rom_rd_addr & cart_mask);

endmodule

`default_nettype wire

// File: verilog/rom_write_seq.sv
// ROM write sequencer
`timescale 1ns/100ps
`default_nettype none

`include "sms_loader_settings.svh"

module rom_write_seq (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire                        cart_download,
	input  wire                        ioctl_wr,
	input  sms_loader_pkg::byte_t      ioctl_dout,
	input  wire                        rom_wr_ack,
	output logic                       ioctl_wait,
	output logic                       rom_wr,     // Request toggle
	output sms_loader_pkg::waddr_t     rom_waddr,
	output sms_loader_pkg::byte_t      rom_wdata
);

	logic old_download;
	logic cart_byte;

	assign cart_byte = ioctl_wr & cart_download;

	// ====================
	// Handshake and address
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			ioctl_wait   <= 1'b0;
			rom_wr       <= 1'b0;
			rom_waddr    <= '0;
		end else begin
			old_download <= cart_download;

			if (cart_download && !old_download) begin
				rom_waddr <= '0; // New cartridge starts at 0
			end else if (ioctl_wait && (rom_wr == rom_wr_ack)) begin
				// Memory echoed the toggle, release host
				ioctl_wait <= 1'b0;
				rom_waddr  <= rom_waddr + 1'b1;
			end

			if (cart_byte) begin
				ioctl_wait <= 1'b1;
				rom_wr     <= ~rom_wr; // Pending until echo matches
			end
		end
	end

	// Data held for the whole pending write
	always_ff @(posedge clk_sys) begin
		if (cart_byte)
			rom_wdata <= ioctl_dout;
	end

endmodule

`default_nettype wire

// File: verilog/sms_loader_pkg.sv
// SMS loader types
`default_nettype none

`include "sms_loader_settings.svh"

package sms_loader_pkg;

	typedef logic [7:0] byte_t;

	// Host byte address
	typedef logic [`SMS_IOCTL_ADDR_W-1:0] ioctl_addr_t;

	// CPU side ROM address
	typedef logic [`SMS_ROM_ADDR_W-1:0] rom_addr_t;

	// External memory write address
	typedef logic [`SMS_WADDR_W-1:0] waddr_t;

	// One cheat, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

// File: verilog/sms_loader_settings.svh
// SMS loader settings
`ifndef SMS_LOADER_SETTINGS_SVH
`define SMS_LOADER_SETTINGS_SVH

// ====================
// Download indexes
// ====================
`define SMS_INDEX_CODE     8'hFF   // Cheat files
`define SMS_INDEX_SYSMODE  8'd4    // Arcade system mode
`define SMS_INDEX_DSW      8'd254  // Arcade DIP switches

// Console file types, low five index bits
`define SMS_INDEX_SMS      5'd1
`define SMS_INDEX_GG       5'd2
`define SMS_EXT_SG         2'd2    // Index bits 6:5 for .SG

// ====================
// Widths
// ====================
`define SMS_IOCTL_ADDR_W   25
`define SMS_ROM_ADDR_W     22
`define SMS_WADDR_W        24

// ====================
// Sizes
// ====================
`define SMS_HEADER_BYTES   512     // Copier header
`define SMS_CODE_BYTES     16      // One cheat code
`define SMS_DSW_COUNT      3

`endif
